// File: design/beat_if.sv
// interface for framed beats from packet decode to channel execute, with modports
`timescale 1ns/10ps

interface beat_if;
	import calc_pkg::*;

	// beat present this cycle
	logic  valid;
	// first beat of a packet, also a restart
	logic  sop;
	// last beat of a packet
	logic  eop;
	// beat payload
	word_t data;
	// room for a new packet, qualifies sop only
	logic  ready;

	// decode side drives the registered beat
	modport decode (
		output valid, sop, eop, data,
		input  ready
	);

	// execute side consumes beats and returns readiness
	modport execute (
		input  valid, sop, eop, data,
		output ready
	);

endinterface

// File: design/calc_ctl_top.sv
// top level: two calculation channels, result merge and shared output fifo
`timescale 1ns/10ps

module calc_ctl_top #(
	parameter int CHAN_DEPTH = calc_pkg::CHAN_DEPTH_DEF,
	parameter int FIFO_DEPTH = calc_pkg::FIFO_DEPTH_DEF
) (
	input  logic              sys_clk,
	input  logic              sys_rst_n,
	// channel 0
	input  logic              matrix_memory_sop_0,
	input  logic              matrix_memory_eop_0,
	input  logic              matrix_memory_vld_0,
	input  calc_pkg::word_t   matrix_memory_data_0,
	output logic              pkt_enable_0,
	// channel 1
	input  logic              matrix_memory_sop_1,
	input  logic              matrix_memory_eop_1,
	input  logic              matrix_memory_vld_1,
	input  calc_pkg::word_t   matrix_memory_data_1,
	output logic              pkt_enable_1,
	// result readout
	output calc_pkg::result_t result_fifo_rdat,
	output logic              result_fifo_empty,
	input  logic              result_fifo_rden
);
	import calc_pkg::*;

	// channel record handshakes
	logic    res_valid_0;
	logic    res_ready_0;
	result_t res_data_0;
	logic    res_valid_1;
	logic    res_ready_1;
	result_t res_data_1;

	// merge to fifo
	logic    fifo_wr_en;
	result_t fifo_wr_data;
	logic    fifo_almost_full;

	// -------------------------------------------------------------------------
	// channel 0
	// -------------------------------------------------------------------------

	beat_if u_beat_0 ();

	packet_decode u_packet_decode_0 (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.sop        (matrix_memory_sop_0),
		.eop        (matrix_memory_eop_0),
		.vld        (matrix_memory_vld_0),
		.data       (matrix_memory_data_0),
		.pkt_enable (pkt_enable_0),
		.beat       (u_beat_0)
	);

	channel_execute #(
		.CHAN_DEPTH (CHAN_DEPTH)
	) u_channel_execute_0 (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.chan_id    (1'b0),
		.beat       (u_beat_0),
		.res_valid  (res_valid_0),
		.res_ready  (res_ready_0),
		.res_data   (res_data_0)
	);

	// -------------------------------------------------------------------------
	// channel 1
	// -------------------------------------------------------------------------

	beat_if u_beat_1 ();

	packet_decode u_packet_decode_1 (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.sop        (matrix_memory_sop_1),
		.eop        (matrix_memory_eop_1),
		.vld        (matrix_memory_vld_1),
		.data       (matrix_memory_data_1),
		.pkt_enable (pkt_enable_1),
		.beat       (u_beat_1)
	);

	channel_execute #(
		.CHAN_DEPTH (CHAN_DEPTH)
	) u_channel_execute_1 (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.chan_id    (1'b1),
		.beat       (u_beat_1),
		.res_valid  (res_valid_1),
		.res_ready  (res_ready_1),
		.res_data   (res_data_1)
	);

	// -------------------------------------------------------------------------
	// result path
	// -------------------------------------------------------------------------

	result_merge u_result_merge (
		.sys_clk     (sys_clk),
		.sys_rst_n   (sys_rst_n),
		.res_valid_0 (res_valid_0),
		.res_ready_0 (res_ready_0),
		.res_data_0  (res_data_0),
		.res_valid_1 (res_valid_1),
		.res_ready_1 (res_ready_1),
		.res_data_1  (res_data_1),
		.almost_full (fifo_almost_full),
		.wr_en       (fifo_wr_en),
		.wr_data     (fifo_wr_data)
	);

	result_fifo #(
		.FIFO_DEPTH (FIFO_DEPTH)
	) u_result_fifo (
		.sys_clk     (sys_clk),
		.sys_rst_n   (sys_rst_n),
		.wr_en       (fifo_wr_en),
		.wr_data     (fifo_wr_data),
		.rden        (result_fifo_rden),
		.rdat        (result_fifo_rdat),
		.empty       (result_fifo_empty),
		.almost_full (fifo_almost_full)
	);

endmodule

// File: design/calc_pkg.sv
// package with word, sum, count and result record types and default sizes

package calc_pkg;

	// -------------------------------------------------------------------------
	// data widths
	// -------------------------------------------------------------------------

	// one matrix memory data word
	typedef logic [31:0] word_t;

	// packet word sum, wraps modulo 2^48
	typedef logic [47:0] sum_t;

	// packet beat count, wraps modulo 2^15
	typedef logic [14:0] count_t;

	// result record
	// bit 63 channel, 62..48 beat count, 47..0 word sum
	typedef logic [63:0] result_t;

	// -------------------------------------------------------------------------
	// sizes
	// -------------------------------------------------------------------------

	// fixed by the per-channel top level ports
	localparam int NUM_CHAN = 2;
	// per-channel result queue depth
	localparam int CHAN_DEPTH_DEF = 4;
	// shared output fifo depth
	localparam int FIFO_DEPTH_DEF = 16;

endpackage

// File: design/channel_execute.sv
// channel execute: packet sum and count reduction, result queue and admission readiness
`timescale 1ns/10ps

module channel_execute #(
	parameter int CHAN_DEPTH = calc_pkg::CHAN_DEPTH_DEF
) (
	input  logic              sys_clk,
	input  logic              sys_rst_n,
	input  logic              chan_id,
	beat_if.execute           beat,
	output logic              res_valid,
	input  logic              res_ready,
	output calc_pkg::result_t res_data
);
	import calc_pkg::*;

	localparam int PTR_W = (CHAN_DEPTH > 1) ? $clog2(CHAN_DEPTH) : 1;
	localparam int CNT_W = $clog2(CHAN_DEPTH + 1);
	// one extra bit for queue plus open packet
	localparam int OCC_W = CNT_W + 1;

	// running reduction
	sum_t             acc_sum;
	count_t           acc_cnt;
	sum_t             sum_nxt;
	count_t           cnt_nxt;
	logic             pkt_open;

	// result queue
	result_t          q_mem [CHAN_DEPTH];
	logic [PTR_W-1:0] q_wr_ptr;
	logic [PTR_W-1:0] q_rd_ptr;
	logic [CNT_W-1:0] q_count;
	logic             q_wr;
	logic             q_rd;

	// admission
	logic             pkt_busy;
	logic [OCC_W-1:0] occupancy;

	// circular pointer step, depth need not be a power of two
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(CHAN_DEPTH - 1)) begin
			return '0;
		end
		return ptr + PTR_W'(1);
	endfunction

	// -------------------------------------------------------------------------
	// sum and count
	// -------------------------------------------------------------------------

	// sop loads the first word, later beats add on
	always_comb begin
		if (beat.sop) begin
			sum_nxt = sum_t'(beat.data);
			cnt_nxt = count_t'(1);
		end else begin
			sum_nxt = acc_sum + sum_t'(beat.data);
			cnt_nxt = acc_cnt + count_t'(1);
		end
	end

	always_ff @(posedge sys_clk) begin
		if (beat.valid) begin
			acc_sum <= sum_nxt;
			acc_cnt <= cnt_nxt;
		end
	end

	// open until eop, a restart keeps it open
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			pkt_open <= 1'b0;
		end else if (beat.valid) begin
			pkt_open <= ~beat.eop;
		end
	end

	// -------------------------------------------------------------------------
	// result queue
	// -------------------------------------------------------------------------

	assign q_wr = beat.valid & beat.eop;
	assign q_rd = res_valid & res_ready;

	// record packs channel, beat count and sum
	always_ff @(posedge sys_clk) begin
		if (q_wr) begin
			q_mem[q_wr_ptr] <= {chan_id, cnt_nxt, sum_nxt};
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			q_wr_ptr <= '0;
			q_rd_ptr <= '0;
			q_count  <= '0;
		end else begin
			if (q_wr) begin
				q_wr_ptr <= ptr_inc(q_wr_ptr);
			end
			if (q_rd) begin
				q_rd_ptr <= ptr_inc(q_rd_ptr);
			end
			q_count <= q_count + CNT_W'(q_wr) - CNT_W'(q_rd);
		end
	end

	// head entry held until popped
	assign res_valid = (q_count != '0);
	assign res_data  = q_mem[q_rd_ptr];

	// -------------------------------------------------------------------------
	// admission readiness
	// -------------------------------------------------------------------------

	// a beat still in the decode register already owns a slot
	assign pkt_busy   = pkt_open | beat.valid;
	assign occupancy  = OCC_W'(q_count) + OCC_W'(pkt_busy);
	assign beat.ready = (occupancy < OCC_W'(CHAN_DEPTH));

endmodule

// File: design/packet_decode.sv
// packet decode: per-channel framing tracker and input beat register
`timescale 1ns/10ps

module packet_decode (
	input  logic            sys_clk,
	input  logic            sys_rst_n,
	input  logic            sop,
	input  logic            eop,
	input  logic            vld,
	input  calc_pkg::word_t data,
	output logic            pkt_enable,
	beat_if.decode          beat
);

	// framing state
	typedef enum logic {
		IDLE,
		IN_PKT
	} state_t;

	state_t state;
	// sop admitted this cycle
	logic   sop_take;
	// sop refused for lack of room
	logic   sop_drop;
	// beat forwarded to execute
	logic   beat_take;

	// -------------------------------------------------------------------------
	// admission
	// -------------------------------------------------------------------------

	// execute readiness goes straight out as pkt_enable
	assign pkt_enable = beat.ready;

	assign sop_take = vld & sop & beat.ready;
	assign sop_drop = vld & sop & ~beat.ready;

	// body beats pass only inside an open packet
	// stray vld beats in IDLE are dropped here
	assign beat_take = sop_take | (vld & ~sop & (state == IN_PKT));

	// -------------------------------------------------------------------------
	// framing state
	// -------------------------------------------------------------------------

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state <= IDLE;
		end else if (sop_take) begin
			// single-beat packet closes at once
			state <= eop ? IDLE : IN_PKT;
		end else if (sop_drop) begin
			// refused sop starts nothing, rest of it is discarded
			state <= IDLE;
		end else if (beat_take && eop) begin
			state <= IDLE;
		end
	end

	// -------------------------------------------------------------------------
	// beat register towards execute
	// -------------------------------------------------------------------------

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			beat.valid <= 1'b0;
			beat.sop   <= 1'b0;
			beat.eop   <= 1'b0;
		end else begin
			beat.valid <= beat_take;
			beat.sop   <= sop_take;
			beat.eop   <= beat_take & eop;
		end
	end

	// payload only
	always_ff @(posedge sys_clk) begin
		if (beat_take) begin
			beat.data <= data;
		end
	end

endmodule

// File: design/result_fifo.sv
// result fifo: show-ahead output buffer with occupancy count and almost-full flag
`timescale 1ns/10ps

module result_fifo #(
	parameter int FIFO_DEPTH = calc_pkg::FIFO_DEPTH_DEF
) (
	input  logic              sys_clk,
	input  logic              sys_rst_n,
	input  logic              wr_en,
	input  calc_pkg::result_t wr_data,
	input  logic              rden,
	output calc_pkg::result_t rdat,
	output logic              empty,
	output logic              almost_full
);
	import calc_pkg::*;

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
	// leaves room for the two merge writes in flight
	localparam int AF_LEVEL = FIFO_DEPTH - 2;

	result_t          mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             full;
	logic             wr_ok;
	logic             rd_ok;

	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
		if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
			return '0;
		end
		return ptr + PTR_W'(1);
	endfunction

	assign full  = (count == CNT_W'(FIFO_DEPTH));
	assign empty = (count == '0);
	// pop on empty is ignored
	assign wr_ok = wr_en & ~full;
	assign rd_ok = rden & ~empty;

	always_ff @(posedge sys_clk) begin
		if (wr_ok) begin
			mem[wr_ptr] <= wr_data;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_ok) begin
				wr_ptr <= ptr_inc(wr_ptr);
			end
			if (rd_ok) begin
				rd_ptr <= ptr_inc(rd_ptr);
			end
			count <= count + CNT_W'(wr_ok) - CNT_W'(rd_ok);
		end
	end

	// show-ahead head entry
	assign rdat        = mem[rd_ptr];
	assign almost_full = (count >= CNT_W'(AF_LEVEL));

endmodule

// File: design/result_merge.sv
// result merge: round-robin arbiter and two-stage write pipeline into the output fifo
`timescale 1ns/10ps

module result_merge (
	input  logic              sys_clk,
	input  logic              sys_rst_n,
	input  logic              res_valid_0,
	output logic              res_ready_0,
	input  calc_pkg::result_t res_data_0,
	input  logic              res_valid_1,
	output logic              res_ready_1,
	input  calc_pkg::result_t res_data_1,
	input  logic              almost_full,
	output logic              wr_en,
	output calc_pkg::result_t wr_data
);
	import calc_pkg::*;

	localparam int SEL_W = $clog2(NUM_CHAN);

	// channel holding priority this cycle
	logic [SEL_W-1:0] rr_ptr;
	logic             gnt_0;
	logic             gnt_1;
	// first pipeline stage
	logic             s1_valid;
	result_t          s1_data;

	// -------------------------------------------------------------------------
	// arbitration
	// -------------------------------------------------------------------------

	// almost_full blocks all grants, queues fill behind it
	always_comb begin
		gnt_0 = 1'b0;
		gnt_1 = 1'b0;
		if (!almost_full) begin
			if (rr_ptr == SEL_W'(0)) begin
				gnt_0 = res_valid_0;
				gnt_1 = res_valid_1 & ~res_valid_0;
			end else begin
				gnt_1 = res_valid_1;
				gnt_0 = res_valid_0 & ~res_valid_1;
			end
		end
	end

	// grant pops the channel queue
	assign res_ready_0 = gnt_0;
	assign res_ready_1 = gnt_1;

	// priority passes to the other channel after a grant
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rr_ptr <= '0;
		end else if (gnt_0) begin
			rr_ptr <= SEL_W'(1);
		end else if (gnt_1) begin
			rr_ptr <= SEL_W'(0);
		end
	end

	// -------------------------------------------------------------------------
	// write pipeline, two records in flight at most
	// -------------------------------------------------------------------------

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			s1_valid <= 1'b0;
			wr_en    <= 1'b0;
		end else begin
			s1_valid <= gnt_0 | gnt_1;
			wr_en    <= s1_valid;
		end
	end

	always_ff @(posedge sys_clk) begin
		s1_data <= gnt_0 ? res_data_0 : res_data_1;
		wr_data <= s1_data;
	end

endmodule

// File: files.f
design/calc_pkg.sv
design/beat_if.sv
design/packet_decode.sv
design/channel_execute.sv
design/result_merge.sv
design/result_fifo.sv
design/calc_ctl_top.sv
tb/calc_ctl_asserts.sv
tb/calc_ctl_tb.sv

// File: tb/calc_ctl_asserts.sv
// bound assertions on fifo writes, channel record handshakes and admission outputs
`timescale 1ns/10ps

module calc_ctl_asserts (
	input logic              sys_clk,
	input logic              sys_rst_n,
	input logic              fifo_wr_en,
	input logic              fifo_full,
	input logic              res_valid_0,
	input logic              res_ready_0,
	input calc_pkg::result_t res_data_0,
	input logic              res_valid_1,
	input logic              res_ready_1,
	input calc_pkg::result_t res_data_1,
	input logic              pkt_enable_0,
	input logic              pkt_enable_1
);

	// a write into a full fifo would drop a record
	no_write_when_full: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		!(fifo_wr_en && fifo_full))
		else $error("output fifo written while full");

	// queue head held while the merge has not taken it
	res_stable_0: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		(res_valid_0 && !res_ready_0) |=> $stable(res_data_0))
		else $error("channel 0 record changed while waiting for the merge");

	res_stable_1: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		(res_valid_1 && !res_ready_1) |=> $stable(res_data_1))
		else $error("channel 1 record changed while waiting for the merge");

	// admission outputs always resolved out of reset
	pkt_enable_known: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		!$isunknown({pkt_enable_0, pkt_enable_1}))
		else $error("pkt_enable unknown after reset");

endmodule

bind calc_ctl_top calc_ctl_asserts u_calc_ctl_asserts (
	.sys_clk      (sys_clk),
	.sys_rst_n    (sys_rst_n),
	.fifo_wr_en   (fifo_wr_en),
	.fifo_full    (u_result_fifo.full),
	.res_valid_0  (res_valid_0),
	.res_ready_0  (res_ready_0),
	.res_data_0   (res_data_0),
	.res_valid_1  (res_valid_1),
	.res_ready_1  (res_ready_1),
	.res_data_1   (res_data_1),
	.pkt_enable_0 (pkt_enable_0),
	.pkt_enable_1 (pkt_enable_1)
);

// File: tb/calc_ctl_tb.sv
// testbench with clock, reset, lfsr packet stimulus, reference model, checks and watchdog
`timescale 1ns/10ps

module calc_ctl_tb;
	import calc_pkg::*;

	localparam int CLK_PERIOD   = 8;
	localparam int CHAN_DEPTH   = CHAN_DEPTH_DEF;
	localparam int NUM_PKTS     = 80;
	localparam int MAX_BEATS    = 8;
	localparam int MAX_GAP      = 3;
	localparam int DRAIN_CYCLES = 400;
	// twice every packet at full length and gap, plus the drain
	localparam int WATCHDOG_NS  =
		(NUM_PKTS * (MAX_BEATS + MAX_GAP + 1) * 2 + DRAIN_CYCLES + 100) * CLK_PERIOD;

	logic        sys_clk;
	logic        sys_rst_n;
	logic [1:0]  sop_in;
	logic [1:0]  eop_in;
	logic [1:0]  vld_in;
	word_t       data_in [2];
	wire  [1:0]  pkt_enable;
	result_t     result_fifo_rdat;
	logic        result_fifo_empty;
	logic        result_fifo_rden;

	// stimulus state per channel
	logic [31:0] lfsr_state;
	int          beats_left [2];
	int          gap_left [2];
	int          pkts_sent [2];
	int          cycle;

	// reference model
	logic        in_pkt [2];
	sum_t        m_sum [2];
	count_t      m_cnt [2];
	result_t     exp_q0 [$];
	result_t     exp_q1 [$];
	int          rejected [2];
	logic        saw_stall [2];
	int          records_checked;
	int          value_errors;
	int          other_errors;
	int          quiet;

	calc_ctl_top #(
		.CHAN_DEPTH (CHAN_DEPTH)
	) u_calc_ctl_top (
		.sys_clk              (sys_clk),
		.sys_rst_n            (sys_rst_n),
		.matrix_memory_sop_0  (sop_in[0]),
		.matrix_memory_eop_0  (eop_in[0]),
		.matrix_memory_vld_0  (vld_in[0]),
		.matrix_memory_data_0 (data_in[0]),
		.pkt_enable_0         (pkt_enable[0]),
		.matrix_memory_sop_1  (sop_in[1]),
		.matrix_memory_eop_1  (eop_in[1]),
		.matrix_memory_vld_1  (vld_in[1]),
		.matrix_memory_data_1 (data_in[1]),
		.pkt_enable_1         (pkt_enable[1]),
		.result_fifo_rdat     (result_fifo_rdat),
		.result_fifo_empty    (result_fifo_empty),
		.result_fifo_rden     (result_fifo_rden)
	);

	initial begin
		sys_clk = 1'b0;
		forever #(CLK_PERIOD / 2) sys_clk = ~sys_clk;
	end

	// ------------------------------------------------------------------------
	// random bits
	// ------------------------------------------------------------------------

	// galois lfsr with taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 32'h80200003;
		end
		return s >> 1;
	endfunction

	// one lfsr step per bit taken
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
		return v;
	endfunction

	// ------------------------------------------------------------------------
	// stimulus
	// ------------------------------------------------------------------------

	// one cycle of one channel where packets start regardless of pkt_enable
	task automatic drive_channel(input int ch);
		logic start;
		logic stray;
		start = 1'b0;
		stray = 1'b0;
		if (beats_left[ch] > 0) begin
			// rare sop inside an open packet restarts it
			start = (take_bits(4) == 0) && (pkts_sent[ch] < NUM_PKTS);
		end else if (gap_left[ch] > 0) begin
			gap_left[ch]--;
			stray = (take_bits(3) == 0);
		end else if (pkts_sent[ch] < NUM_PKTS) begin
			start = 1'b1;
		end
		if (start) begin
			beats_left[ch] = int'(take_bits(3)) + 1;
			pkts_sent[ch]++;
		end
		if (beats_left[ch] > 0) begin
			vld_in[ch]  <= 1'b1;
			sop_in[ch]  <= start;
			eop_in[ch]  <= (beats_left[ch] == 1);
			data_in[ch] <= take_bits(32);
			beats_left[ch]--;
			if (beats_left[ch] == 0) begin
				gap_left[ch] = int'(take_bits(2));
			end
		end else begin
			// stray beat outside any packet with random eop
			vld_in[ch]  <= stray;
			sop_in[ch]  <= 1'b0;
			eop_in[ch]  <= 1'(take_bits(1));
			data_in[ch] <= take_bits(32);
		end
	endtask

	// random reads with long forced stalls
	task automatic drive_read(input logic drain);
		if (drain) begin
			result_fifo_rden <= 1'b1;
		end else if ((cycle % 256) >= 160) begin
			result_fifo_rden <= 1'b0;
		end else begin
			result_fifo_rden <= 1'(take_bits(1));
		end
	endtask

	// ------------------------------------------------------------------------
	// reference model and checks
	// ------------------------------------------------------------------------

	task automatic push_expected(input int ch, input result_t rec);
		if (ch == 0) begin
			exp_q0.push_back(rec);
		end else begin
			exp_q1.push_back(rec);
		end
	endtask

	// decides what the coming edge accepts on one channel
	task automatic model_channel(input int ch);
		logic take;
		int   owed;
		take = 1'b0;
		owed = (ch == 0) ? exp_q0.size() : exp_q1.size();
		// channel queue never holds more than the records still owed
		if (owed + 1 < CHAN_DEPTH && pkt_enable[ch] !== 1'b1) begin
			$display("** Error at %0t: pkt_enable_%0d expected 1, got %b", $time, ch,
				pkt_enable[ch]);
			value_errors++;
		end
		if (vld_in[ch] && sop_in[ch]) begin
			if (pkt_enable[ch]) begin
				m_sum[ch]  = sum_t'(data_in[ch]);
				m_cnt[ch]  = count_t'(1);
				in_pkt[ch] = 1'b1;
				take       = 1'b1;
			end else begin
				// refused sop discards its body too
				in_pkt[ch] = 1'b0;
				rejected[ch]++;
			end
		end else if (vld_in[ch] && in_pkt[ch]) begin
			m_sum[ch] = m_sum[ch] + sum_t'(data_in[ch]);
			m_cnt[ch] = m_cnt[ch] + count_t'(1);
			take      = 1'b1;
		end
		if (take && eop_in[ch]) begin
			in_pkt[ch] = 1'b0;
			push_expected(ch, {ch[0], m_cnt[ch], m_sum[ch]});
		end
		if (!pkt_enable[ch]) begin
			saw_stall[ch] = 1'b1;
		end
	endtask

	// record about to be popped against its channel's queue head
	task automatic check_pop();
		result_t got;
		result_t exp;
		got = result_fifo_rdat;
		if (got[63] == 1'b0 && exp_q0.size() == 0) begin
			$display("record popped on channel 0 at %0t with none expected", $time);
			other_errors++;
			return;
		end
		if (got[63] == 1'b1 && exp_q1.size() == 0) begin
			$display("record popped on channel 1 at %0t with none expected", $time);
			other_errors++;
			return;
		end
		exp = got[63] ? exp_q1.pop_front() : exp_q0.pop_front();
		records_checked++;
		if (got !== exp) begin
			$display("** Error at %0t: result_fifo_rdat expected %h, got %h", $time, exp, got);
			value_errors++;
		end
	endtask

	// inputs and outputs are settled at the falling edge
	always @(negedge sys_clk) begin
		if (sys_rst_n) begin
			model_channel(0);
			model_channel(1);
			if (result_fifo_rden && !result_fifo_empty) begin
				check_pop();
			end
		end
	end

	// ------------------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------------------

	initial begin
		lfsr_state       = 32'he5f4;
		sys_rst_n        = 1'b0;
		sop_in           = '0;
		eop_in           = '0;
		vld_in           = '0;
		data_in[0]       = '0;
		data_in[1]       = '0;
		result_fifo_rden = 1'b0;
		cycle            = 0;
		quiet            = 0;
		records_checked  = 0;
		value_errors     = 0;
		other_errors     = 0;
		for (int ch = 0; ch < 2; ch++) begin
			beats_left[ch] = 0;
			gap_left[ch]   = 0;
			pkts_sent[ch]  = 0;
			in_pkt[ch]     = 1'b0;
			m_sum[ch]      = '0;
			m_cnt[ch]      = '0;
			rejected[ch]   = 0;
			saw_stall[ch]  = 1'b0;
		end
		repeat (4) @(posedge sys_clk);
		sys_rst_n <= 1'b1;

		// idle state out of reset
		@(negedge sys_clk);
		if (result_fifo_empty !== 1'b1) begin
			$display("** Error at %0t: result_fifo_empty expected 1, got %b", $time,
				result_fifo_empty);
			value_errors++;
		end
		if (pkt_enable !== 2'b11) begin
			$display("** Error at %0t: pkt_enable expected 11, got %b", $time, pkt_enable);
			value_errors++;
		end

		// random traffic on both channels
		while (pkts_sent[0] < NUM_PKTS || pkts_sent[1] < NUM_PKTS ||
			beats_left[0] > 0 || beats_left[1] > 0) begin
			@(posedge sys_clk);
			drive_channel(0);
			drive_channel(1);
			drive_read(1'b0);
			cycle++;
		end

		// drain until the fifo stays empty
		for (int i = 0; i < DRAIN_CYCLES && quiet < 16; i++) begin
			@(posedge sys_clk);
			drive_channel(0);
			drive_channel(1);
			drive_read(1'b1);
			@(negedge sys_clk);
			quiet = result_fifo_empty ? quiet + 1 : 0;
		end

		if (exp_q0.size() != 0 || exp_q1.size() != 0) begin
			$display("records lost after drain: channel 0 missing %0d, channel 1 missing %0d",
				exp_q0.size(), exp_q1.size());
			other_errors++;
		end
		if (!saw_stall[0] && !saw_stall[1]) begin
			$display("pkt_enable never fell during the read stalls");
			other_errors++;
		end
		if (rejected[0] + rejected[1] == 0) begin
			$display("no sop was offered while pkt_enable was low");
			other_errors++;
		end
		if (records_checked == 0) begin
			$display("no record was read from the output fifo");
			other_errors++;
		end
		$display("records checked %0d, value errors %0d, other errors %0d",
			records_checked, value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	// hung run guard
	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
		$display("Test failed");
		$finish;
	end

endmodule
